// File: include/vrf_macros.svh
//////////////////////////////
// Vector register file geometry
// Register count, word width, byte
// slots per word and read ports
//////////////////////////////

`ifndef VRF_MACROS_SVH
`define VRF_MACROS_SVH

// Number of architectural vector registers
`define VRF_NR_WORDS 32

// Bits held by one vector register
`define VRF_WORD_WIDTH 64

// Byte slots per register, also the element count at SEW 8
`define VRF_NR_BYTES 8

// Combinational read ports
`define VRF_NR_READ_PORTS 2

`endif

// File: hdl/vrf_pkg.sv
//////////////////////////////
// Vector register file types
// Shared by RTL and testbench
//////////////////////////////

`include "vrf_macros.svh"

package vrf_pkg;

  // Register index, 5 bits for 32 registers
  typedef logic [$clog2(`VRF_NR_WORDS)-1:0] vreg_addr_t;

  // One full register word
  typedef logic [`VRF_WORD_WIDTH-1:0] vrf_word_t;

  // Byte strobe, one bit per byte
  typedef logic [`VRF_NR_BYTES-1:0] vrf_strb_t;

  // Element mask, bit k enables element k
  typedef logic [`VRF_NR_BYTES-1:0] vrf_emask_t;

  // Element width code
  // 0 -> 8 bit, 1 -> 16 bit, 2 -> 32 bit, 3 -> 64 bit
  typedef logic [1:0] vrf_sew_t;

  // Vector length in elements, 0 up to 8
  typedef logic [$clog2(`VRF_NR_BYTES):0] vrf_vl_t;

endpackage

// File: hdl/vrf_clk_gate.sv
//////////////////////////////
// Integrated clock gate
// Low-transparent enable latch
// followed by an AND stage
//////////////////////////////

`timescale 1ns/1ps

module vrf_clk_gate (
  input  logic clk,
  input  logic en_i,
  output logic clk_o
);

  // Enable held while the clock is high
  logic en_q;

  // Transparent during the low phase only
  always_latch begin
    if (!clk) begin
      en_q <= en_i;
    end
  end

  // Enable is stable across the high phase, so no glitch
  assign clk_o = clk & en_q;

endmodule

// File: hdl/vrf_cfg_regs.sv
//////////////////////////////
// Vector configuration registers
// SEW and VL, loaded by strobe
//////////////////////////////

`timescale 1ns/1ps

`include "vrf_macros.svh"

module vrf_cfg_regs (
  input  logic              clk,
  input  logic              rst_n_i,
  // Configuration write
  input  logic              cfg_we_i,
  input  vrf_pkg::vrf_sew_t cfg_sew_i,
  input  vrf_pkg::vrf_vl_t  cfg_vl_i,
  // Current configuration
  output vrf_pkg::vrf_sew_t sew_o,
  output vrf_pkg::vrf_vl_t  vl_o
);

  // Registered configuration
  vrf_pkg::vrf_sew_t sew_q;
  vrf_pkg::vrf_vl_t  vl_q;

  // Reset to 64 bit elements over the full word
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sew_q <= vrf_pkg::vrf_sew_t'(3);
      vl_q  <= vrf_pkg::vrf_vl_t'(`VRF_NR_BYTES);
    end else if (cfg_we_i) begin
      // Used by writes from the next cycle on
      sew_q <= cfg_sew_i;
      vl_q  <= cfg_vl_i;
    end
  end

  // Straight to the mask unit
  assign sew_o = sew_q;
  assign vl_o  = vl_q;

endmodule

// File: hdl/vrf_wr_mask.sv
//////////////////////////////
// Write mask unit
// Element write to byte strobes,
// covering element mask and VL tail
//////////////////////////////

`timescale 1ns/1ps

`include "vrf_macros.svh"

module vrf_wr_mask (
  input  logic                wr_en_i,
  input  vrf_pkg::vrf_emask_t wr_emask_i,
  // Current configuration
  input  vrf_pkg::vrf_sew_t   sew_i,
  input  vrf_pkg::vrf_vl_t    vl_i,
  // Byte strobes to the register file
  output vrf_pkg::vrf_strb_t  wr_strb_o
);

  //////////////////////////////
  // Per byte decode
  //////////////////////////////

  // Element that owns each byte
  logic [$clog2(`VRF_NR_BYTES)-1:0] elem_idx [`VRF_NR_BYTES];

  // Element lies below VL
  logic [`VRF_NR_BYTES-1:0] in_vl;

  // Element mask bit selected for each byte
  logic [`VRF_NR_BYTES-1:0] elem_en;

  for (genvar b = 0; b < `VRF_NR_BYTES; b++) begin : gen_byte
    // Element spans 2^SEW bytes
    assign elem_idx[b] = ($clog2(`VRF_NR_BYTES))'(b >> sew_i);

    // VL above the element count covers the whole word
    assign in_vl[b] = vrf_pkg::vrf_vl_t'(elem_idx[b]) < vl_i;

    // Same mask bit for all bytes of one element
    assign elem_en[b] = wr_emask_i[elem_idx[b]];

    // Tail and mask, then write enable
    assign wr_strb_o[b] = wr_en_i & in_vl[b] & elem_en[b];
  end

endmodule

// File: hdl/vrf_regfile.sv
//////////////////////////////
// Latch based vector register file
// Global gated write clock, one gated
// latch clock per register byte and
// two combinational read ports
//////////////////////////////

`timescale 1ns/1ps

`include "vrf_macros.svh"

module vrf_regfile (
  input  logic                                           clk,
  // Write port
  input  logic                                           we_i,
  input  vrf_pkg::vreg_addr_t                            waddr_i,
  input  vrf_pkg::vrf_word_t                             wdata_i,
  input  vrf_pkg::vrf_strb_t                             wbe_i,
  // Read ports
  input  vrf_pkg::vreg_addr_t [`VRF_NR_READ_PORTS-1:0]   raddr_i,
  output vrf_pkg::vrf_word_t  [`VRF_NR_READ_PORTS-1:0]   rdata_o
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Write clock, only toggles on cycles with a byte to store
  logic gclk;

  // Storage, register by byte by bit
  logic [`VRF_NR_WORDS-1:0][`VRF_NR_BYTES-1:0][7:0] mem;

  // Write data captured at the write edge
  vrf_pkg::vrf_word_t wdata_q;

  // One-hot byte select over the whole array
  logic [`VRF_NR_WORDS-1:0][`VRF_NR_BYTES-1:0] wsel;

  //////////////////////////////
  // Write path
  //////////////////////////////

  // Global gate opens when any byte is strobed
  vrf_clk_gate i_wr_cg (
    .clk   (clk),
    .en_i  (we_i & (|wbe_i)),
    .clk_o (gclk)
  );

  // Data stays put until the next write edge
  always_ff @(posedge gclk) begin
    wdata_q <= wdata_i;
  end

  for (genvar r = 0; r < `VRF_NR_WORDS; r++) begin : gen_reg
    for (genvar b = 0; b < `VRF_NR_BYTES; b++) begin : gen_byte
      logic clk_latch;

      // Address decode and byte strobe
      assign wsel[r][b] = we_i && wbe_i[b] && (waddr_i == r);

      // Opens this byte latch for the high phase of the write cycle
      vrf_clk_gate i_byte_cg (
        .clk   (gclk),
        .en_i  (wsel[r][b]),
        .clk_o (clk_latch)
      );

      // Byte storage
      always_latch begin
        if (clk_latch) begin
          mem[r][b] <= wdata_q[b*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  // Whole word mux per port
  for (genvar p = 0; p < `VRF_NR_READ_PORTS; p++) begin : gen_rd
    assign rdata_o[p] = mem[raddr_i[p]];
  end

endmodule

// File: hdl/vrf_top.sv
//////////////////////////////
// Vector register file subsystem
// Configuration, write mask and
// latch register file
//////////////////////////////

`timescale 1ns/1ps

`include "vrf_macros.svh"

module vrf_top (
  input  logic                                           clk,
  input  logic                                           rst_n_i,
  // Configuration port
  input  logic                                           cfg_we_i,
  input  vrf_pkg::vrf_sew_t                              cfg_sew_i,
  input  vrf_pkg::vrf_vl_t                               cfg_vl_i,
  // Write port
  input  logic                                           wr_en_i,
  input  vrf_pkg::vreg_addr_t                            wr_vreg_i,
  input  vrf_pkg::vrf_word_t                             wr_data_i,
  input  vrf_pkg::vrf_emask_t                            wr_emask_i,
  // Read ports
  input  vrf_pkg::vreg_addr_t [`VRF_NR_READ_PORTS-1:0]   rd_vreg_i,
  output vrf_pkg::vrf_word_t  [`VRF_NR_READ_PORTS-1:0]   rd_data_o
);

  // Current configuration
  vrf_pkg::vrf_sew_t  sew;
  vrf_pkg::vrf_vl_t   vl;

  // Byte strobes for this cycle's write
  vrf_pkg::vrf_strb_t wr_strb;

  // SEW and VL state
  vrf_cfg_regs i_cfg_regs (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cfg_we_i  (cfg_we_i),
    .cfg_sew_i (cfg_sew_i),
    .cfg_vl_i  (cfg_vl_i),
    .sew_o     (sew),
    .vl_o      (vl)
  );

  // Element write to byte strobes
  vrf_wr_mask i_wr_mask (
    .wr_en_i    (wr_en_i),
    .wr_emask_i (wr_emask_i),
    .sew_i      (sew),
    .vl_i       (vl),
    .wr_strb_o  (wr_strb)
  );

  // Storage
  vrf_regfile i_regfile (
    .clk     (clk),
    .we_i    (wr_en_i),
    .waddr_i (wr_vreg_i),
    .wdata_i (wr_data_i),
    .wbe_i   (wr_strb),
    .raddr_i (rd_vreg_i),
    .rdata_o (rd_data_o)
  );

endmodule

// File: dv/vrf_assertions.sv
//////////////////////////////
// Write path and configuration checks
// Bound into the register file and
// the configuration registers
//////////////////////////////

`timescale 1ns/1ps

`include "vrf_macros.svh"

module vrf_assertions (
  input logic                clk,
  input logic                rst_n_i,
  input logic                we_i,
  input vrf_pkg::vrf_strb_t  wbe_i,
  input vrf_pkg::vreg_addr_t waddr_i,
  input vrf_pkg::vrf_vl_t    vl_i
);

  // Strobes only with an active write
  a_strb_needs_we: assert property (@(posedge clk) disable iff (!rst_n_i)
    !we_i |-> (wbe_i == '0))
    else $error("byte strobe set while the write enable is low");

  // Registered VL stays within the element slots
  a_vl_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    vl_i <= vrf_pkg::vrf_vl_t'(`VRF_NR_BYTES))
    else $error("registered VL above the slot count");

  // Known address on every strobed write
  a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    (|wbe_i) |-> !$isunknown(waddr_i))
    else $error("write address unknown with a byte strobe set");

endmodule

// Register file side, no reset and no VL here
bind vrf_regfile vrf_assertions i_wr_asrt (
  .clk (clk), .rst_n_i (1'b1), .we_i (we_i), .wbe_i (wbe_i),
  .waddr_i (waddr_i), .vl_i (vrf_pkg::vrf_vl_t'(`VRF_NR_BYTES))
);

// Configuration side, write checks tied off
bind vrf_cfg_regs vrf_assertions i_cfg_asrt (
  .clk (clk), .rst_n_i (rst_n_i), .we_i (1'b0), .wbe_i ('0),
  .waddr_i ('0), .vl_i (vl_q)
);

// File: dv/vrf_tb.sv
//////////////////////////////
// Vector register file testbench
// Table driven, shadow model,
// watchdog and summary
//////////////////////////////

`timescale 1ns/1ps

`include "vrf_macros.svh"

module vrf_tb;

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 10;
  localparam int NR_TESTS   = 6;
  // Row kinds
  localparam int OP_CFG = 0;
  localparam int OP_WR  = 1;
  localparam int OP_RD  = 2;

  // One table row
  typedef struct packed {
    int                  test;
    int                  op;
    vrf_pkg::vrf_sew_t   sew;
    vrf_pkg::vrf_vl_t    vl;
    vrf_pkg::vreg_addr_t vreg;
    vrf_pkg::vrf_word_t  data;
    bit                  rnd;
    vrf_pkg::vrf_emask_t emask;
    vrf_pkg::vreg_addr_t ra;
    vrf_pkg::vreg_addr_t rb;
  } row_t;

  logic                                         clk;
  logic                                         rst_n_i;
  logic                                         cfg_we_i;
  vrf_pkg::vrf_sew_t                            cfg_sew_i;
  vrf_pkg::vrf_vl_t                             cfg_vl_i;
  logic                                         wr_en_i;
  vrf_pkg::vreg_addr_t                          wr_vreg_i;
  vrf_pkg::vrf_word_t                           wr_data_i;
  vrf_pkg::vrf_emask_t                          wr_emask_i;
  vrf_pkg::vreg_addr_t [`VRF_NR_READ_PORTS-1:0] rd_vreg_i;
  vrf_pkg::vrf_word_t  [`VRF_NR_READ_PORTS-1:0] rd_data_o;

  // Stimulus table and shadow state
  row_t               table_q[$];
  bit                 table_ready = 1'b0;
  vrf_pkg::vrf_word_t shadow [`VRF_NR_WORDS];
  vrf_pkg::vrf_sew_t  sh_sew = 2'd3;
  vrf_pkg::vrf_vl_t   sh_vl  = 4'd8;
  logic [31:0]        rng_state = 32'he6d8_cb38;
  int                 chk_cnt [NR_TESTS];
  int                 err_cnt [NR_TESTS];
  string              test_name [NR_TESTS] = '{"reset defaults", "independent read ports",
    "tail masking by VL", "element masking", "VL zero and large", "configuration timing"};

  vrf_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Random data source
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  //////////////////////////////
  // Table rows
  //////////////////////////////

  function automatic void add_cfg(int t, vrf_pkg::vrf_sew_t sew, vrf_pkg::vrf_vl_t vl);
    table_q.push_back('{t, OP_CFG, sew, vl, '0, '0, 1'b0, '0, '0, '0});
  endfunction

  // Random data when no fixed word is given
  function automatic void add_wr(int t, vrf_pkg::vreg_addr_t vreg, vrf_pkg::vrf_emask_t emask,
                                 vrf_pkg::vrf_word_t data = '0, bit rnd = 1'b1);
    table_q.push_back('{t, OP_WR, '0, '0, vreg, data, rnd, emask, '0, '0});
  endfunction

  function automatic void add_rd(int t, vrf_pkg::vreg_addr_t ra, vrf_pkg::vreg_addr_t rb);
    table_q.push_back('{t, OP_RD, '0, '0, '0, '0, 1'b0, '0, ra, rb});
  endfunction

  function automatic void build_table();
    // Full words under the reset configuration
    add_wr(1, 1, 8'hff);
    add_rd(1, 1, 1);
    add_wr(1, 2, 8'hff);
    add_rd(1, 2, 1);
    add_wr(1, 3, 8'hff);
    add_rd(1, 1, 3);
    // Back to back writes before a dual port read
    add_wr(2, 4, 8'hff);
    add_wr(2, 5, 8'hff);
    add_rd(2, 4, 5);
    add_rd(2, 5, 4);
    add_wr(2, 6, 8'hff);
    add_wr(2, 7, 8'hff);
    add_rd(2, 7, 6);
    // VL below the element count at each SEW
    add_wr(3, 8, 8'hff);
    add_cfg(3, 0, 5);
    add_wr(3, 8, 8'hff);
    add_rd(3, 8, 7);
    add_cfg(3, 1, 3);
    add_wr(3, 8, 8'hff);
    add_rd(3, 8, 8);
    add_cfg(3, 2, 1);
    add_wr(3, 8, 8'hff);
    add_rd(3, 6, 8);
    // Sparse element masks at each SEW
    add_cfg(4, 0, 8);
    add_wr(4, 9, 8'hff);
    add_wr(4, 9, 8'ha5);
    add_rd(4, 9, 8);
    add_cfg(4, 1, 8);
    add_wr(4, 9, 8'h06);
    add_rd(4, 9, 9);
    add_cfg(4, 2, 8);
    add_wr(4, 9, 8'h02);
    add_rd(4, 9, 9);
    // Element 0 off at 64 bit leaves the word alone
    add_cfg(4, 3, 8);
    add_wr(4, 9, 8'hfe);
    add_rd(4, 9, 1);
    add_wr(4, 9, 8'h01);
    add_rd(4, 9, 9);
    // Zero VL and VL past the element count
    add_cfg(5, 3, 8);
    add_wr(5, 10, 8'hff);
    add_rd(5, 10, 9);
    add_cfg(5, 0, 0);
    add_wr(5, 10, 8'hff);
    add_rd(5, 10, 10);
    add_cfg(5, 3, 0);
    add_wr(5, 10, 8'hff);
    add_rd(5, 10, 10);
    add_cfg(5, 2, 8);
    add_wr(5, 10, 8'h01);
    add_rd(5, 10, 10);
    add_cfg(5, 1, 7);
    add_wr(5, 10, 8'hff);
    add_rd(5, 10, 10);
    // Config lands one cycle before the write
    add_cfg(6, 3, 8);
    add_wr(6, 11, 8'hff, 64'h0123_4567_89ab_cdef, 1'b0);
    add_rd(6, 11, 10);
    add_cfg(6, 0, 2);
    add_wr(6, 11, 8'hff, 64'hffee_ddcc_bbaa_9988, 1'b0);
    add_rd(6, 11, 10);
    add_cfg(6, 1, 1);
    add_wr(6, 11, 8'h01);
    add_rd(6, 10, 11);
  endfunction

  //////////////////////////////
  // Shadow model and checks
  //////////////////////////////

  // Byte b sits in element b / element bytes
  // Written only below VL with its mask bit set
  function automatic void model_write(vrf_pkg::vreg_addr_t vreg, vrf_pkg::vrf_word_t data,
                                      vrf_pkg::vrf_emask_t emask);
    int elem_bytes;
    int elem;
    elem_bytes = 1 << sh_sew;
    for (int b = 0; b < `VRF_NR_BYTES; b++) begin
      elem = b / elem_bytes;
      if (elem < int'(sh_vl) && emask[elem]) begin
        shadow[vreg][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endfunction

  // Drive one row, strobes low unless the row sets them
  task automatic apply_row(input row_t r);
    vrf_pkg::vrf_word_t data;
    cfg_we_i = 1'b0;
    wr_en_i  = 1'b0;
    case (r.op)
      OP_CFG: begin
        cfg_we_i  = 1'b1;
        cfg_sew_i = r.sew;
        cfg_vl_i  = r.vl;
        // Model follows from the next row on
        sh_sew    = r.sew;
        sh_vl     = r.vl;
      end
      OP_WR: begin
        data = r.data;
        if (r.rnd) begin
          data[31:0]  = xorshift32();
          data[63:32] = xorshift32();
        end
        wr_en_i    = 1'b1;
        wr_vreg_i  = r.vreg;
        wr_data_i  = data;
        wr_emask_i = r.emask;
        model_write(r.vreg, data, r.emask);
      end
      default: begin
        rd_vreg_i[0] = r.ra;
        rd_vreg_i[1] = r.rb;
      end
    endcase
  endtask

  // Both read ports against the shadow array
  task automatic check_reads(int idx, input row_t r);
    vrf_pkg::vreg_addr_t addr;
    for (int p = 0; p < `VRF_NR_READ_PORTS; p++) begin
      addr = (p == 0) ? r.ra : r.rb;
      chk_cnt[r.test - 1]++;
      if (rd_data_o[p] !== shadow[addr]) begin
        err_cnt[r.test - 1]++;
        $display("error at time %0t: test %0d row %0d port %0d reg %0d read %h, expected %h",
                 $time, r.test, idx, p, addr, rd_data_o[p], shadow[addr]);
      end
    end
  endtask

  // Watchdog allows 20 cycles per row plus reset
  initial begin
    wait (table_ready);
    repeat (table_q.size() * 20 + RST_CYCLES) @(posedge clk);
    $display("timeout: the table did not finish within %0d cycles",
             table_q.size() * 20 + RST_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int total_chk;
    int total_err;
    rst_n_i    = 1'b0;
    cfg_we_i   = 1'b0;
    cfg_sew_i  = '0;
    cfg_vl_i   = '0;
    wr_en_i    = 1'b0;
    wr_vreg_i  = '0;
    wr_data_i  = '0;
    wr_emask_i = '0;
    rd_vreg_i  = '0;
    build_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    // One row per cycle
    // Read rows checked at the following rising edge
    for (int i = 0; i < table_q.size(); i++) begin
      @(negedge clk);
      apply_row(table_q[i]);
      @(posedge clk);
      if (table_q[i].op == OP_RD) begin
        check_reads(i, table_q[i]);
      end
      if (i == table_q.size() - 1 || table_q[i + 1].test != table_q[i].test) begin
        $display("test %0d %s: %0d checks, %0d errors", table_q[i].test,
                 test_name[table_q[i].test - 1], chk_cnt[table_q[i].test - 1],
                 err_cnt[table_q[i].test - 1]);
      end
    end
    @(negedge clk);
    cfg_we_i = 1'b0;
    wr_en_i  = 1'b0;
    // Totals over all tests
    total_chk = 0;
    total_err = 0;
    for (int t = 0; t < NR_TESTS; t++) begin
      total_chk += chk_cnt[t];
      total_err += err_cnt[t];
    end
    $display("summary: %0d tests, %0d checks, %0d errors", NR_TESTS, total_chk, total_err);
    if (total_err == 0 && total_chk > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
hdl/vrf_pkg.sv
hdl/vrf_clk_gate.sv
hdl/vrf_cfg_regs.sv
hdl/vrf_wr_mask.sv
hdl/vrf_regfile.sv
hdl/vrf_top.sv
dv/vrf_assertions.sv
dv/vrf_tb.sv

// File: Bender.yml
package:
  name: vrf

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/vrf_pkg.sv
      - hdl/vrf_clk_gate.sv
      - hdl/vrf_cfg_regs.sv
      - hdl/vrf_wr_mask.sv
      - hdl/vrf_regfile.sv
      - hdl/vrf_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/vrf_assertions.sv
      - dv/vrf_tb.sv
